// File: list.f
+incdir+.
sq_pkg.sv
sq_view_if.sv
sq_addr_gen.sv
sq_buffer.sv
sq_forward.sv
store_queue_top.sv
tb_store_queue.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_store_queue -f list.f \
    -o sim_store_queue > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_store_queue > sim.log 2>&1 || { echo "simulation aborted"; cat sim.log; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sq_addr_gen.sv
`timescale 1ns/1ps

module sq_addr_gen
    import sq_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    squash,
    input  logic    issue,
    input  addr_t   issue_base,
    input  imm_t    issue_offset,
    input  data_t   issue_data,
    input  sq_idx_t issue_idx_in,
    output logic    issue_valid,
    output addr_t   issue_addr,
    output data_t   issue_store_data,
    output sq_idx_t issue_idx
);

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue;
        end
    end

    // effective address is base plus sign-extended offset
    always_ff @(posedge clock) begin
        if (issue) begin
            issue_addr       <= issue_base + {{20{issue_offset[11]}}, issue_offset};
            issue_store_data <= issue_data;
            issue_idx        <= issue_idx_in;
        end
    end

endmodule

// File: sq_buffer.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module sq_buffer
    import sq_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    input  logic        dispatch_valid,
    input  mem_func_t   dispatch_func,
    input  logic        issue_valid,
    input  sq_idx_t     issue_idx,
    input  addr_t       issue_addr,
    input  data_t       issue_store_data,
    input  commit_cnt_t commit_count,
    input  logic        dcache_accept,
    output logic        almost_full,
    output sq_idx_t     tail,
    output commit_cnt_t sent_count,
    output sq_idx_t     head,
    output sq_idx_t     tail_ready,
    output logic        dcache_valid,
    output addr_t       dcache_addr,
    output data_t       dcache_data,
    output mem_func_t   dcache_func,
    sq_view_if.owner    view
);

    // next slot around the ring
    function automatic sq_idx_t step(sq_idx_t idx);
        return (idx == sq_idx_t'(`SQ_SLOTS - 1)) ? '0 : idx + 1'b1;
    endfunction

    // move store data into the lanes its address selects
    function automatic data_t lane_align(data_t data, logic [1:0] offset, mem_func_t func);
        data_t aligned;
        aligned = '0;
        case (func[1:0])
            `MEM_BYTE: aligned[8*offset +: 8] = data[7:0];
            `MEM_HALF: aligned[16*offset[1] +: 16] = data[15:0];
            default:   aligned = data;
        endcase
        return aligned;
    endfunction

    logic      [`SQ_SLOTS-1:0] valid_q, valid_d;
    logic      [`SQ_SLOTS-1:0] ready_q, ready_d;
    logic      [`SQ_SLOTS-1:0] committed_q, committed_d;
    addr_t     [`SQ_SLOTS-1:0] addr_q, addr_d;
    data_t     [`SQ_SLOTS-1:0] data_q, data_d;
    mem_func_t [`SQ_SLOTS-1:0] func_q, func_d;

    sq_idx_t size, size_d;
    sq_idx_t head_d, tail_d;
    // where speculation starts, restored on squash
    sq_idx_t commit_tail, commit_tail_d;
    sq_idx_t commit_size, commit_size_d;

    assign almost_full = (size == sq_idx_t'(`SQ_LEN));

    // oldest entry goes to the cache once committed
    assign dcache_valid = valid_q[head] && committed_q[head];
    assign dcache_addr  = addr_q[head];
    assign dcache_data  = data_q[head];
    assign dcache_func  = func_q[head];

    always_comb begin
        sq_idx_t idx;
        logic    stop;

        valid_d       = valid_q;
        ready_d       = ready_q;
        committed_d   = committed_q;
        addr_d        = addr_q;
        data_d        = data_q;
        func_d        = func_q;
        head_d        = head;
        tail_d        = tail;
        size_d        = size;
        commit_tail_d = commit_tail;
        commit_size_d = commit_size;
        sent_count    = '0;

        // dispatch
        if (dispatch_valid && !almost_full) begin
            valid_d[tail]     = 1'b1;
            ready_d[tail]     = 1'b0;
            committed_d[tail] = 1'b0;
            func_d[tail]      = dispatch_func;
            tail_d            = step(tail);
            size_d            = size_d + 1'b1;
        end

        // issued store fills in address and data
        if (issue_valid && valid_q[issue_idx]) begin
            ready_d[issue_idx] = 1'b1;
            addr_d[issue_idx]  = issue_addr;
            data_d[issue_idx]  = lane_align(issue_store_data, issue_addr[1:0],
                                            func_q[issue_idx]);
        end

        // commit from the oldest uncommitted store, halt on one not ready
        idx  = commit_tail;
        stop = 1'b0;
        for (int i = 0; i < `SQ_COMMIT_WIDTH; i++) begin
            if (!stop && sent_count < commit_count && valid_q[idx] && ready_q[idx]) begin
                committed_d[idx] = 1'b1;
                sent_count       = sent_count + 1'b1;
                commit_tail_d    = step(commit_tail_d);
                commit_size_d    = commit_size_d + 1'b1;
            end else begin
                stop = 1'b1;
            end
            idx = step(idx);
        end

        // drain
        if (dcache_valid && dcache_accept) begin
            valid_d[head]     = 1'b0;
            ready_d[head]     = 1'b0;
            committed_d[head] = 1'b0;
            head_d            = step(head);
            size_d            = size_d - 1'b1;
            commit_size_d     = commit_size_d - 1'b1;
        end

        // only committed stores survive a squash
        if (squash) begin
            valid_d = valid_d & committed_d;
            ready_d = ready_d & committed_d;
            tail_d  = commit_tail_d;
            size_d  = commit_size_d;
        end
    end

    // first store from head that still waits on issue
    always_comb begin
        logic stop;
        stop       = 1'b0;
        tail_ready = head;
        for (int i = 0; i < `SQ_LEN; i++) begin
            if (!stop && valid_q[tail_ready] && ready_q[tail_ready]) begin
                tail_ready = step(tail_ready);
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q     <= '0;
            ready_q     <= '0;
            committed_q <= '0;
            head        <= '0;
            tail        <= '0;
            size        <= '0;
            commit_tail <= '0;
            commit_size <= '0;
        end else begin
            valid_q     <= valid_d;
            ready_q     <= ready_d;
            committed_q <= committed_d;
            head        <= head_d;
            tail        <= tail_d;
            size        <= size_d;
            commit_tail <= commit_tail_d;
            commit_size <= commit_size_d;
        end
    end

    always_ff @(posedge clock) begin
        addr_q <= addr_d;
        data_q <= data_d;
        func_q <= func_d;
    end

    assign view.entry_valid = valid_q;
    assign view.entry_ready = ready_q;
    assign view.entry_addr  = addr_q;
    assign view.entry_data  = data_q;
    assign view.entry_func  = func_q;
    assign view.head        = head;

endmodule

// File: sq_consts.svh
`ifndef SQ_CONSTS_SVH
`define SQ_CONSTS_SVH

// usable entries, one extra slot tells full from empty
`define SQ_LEN 8
`define SQ_SLOTS (`SQ_LEN + 1)
`define SQ_IDX_BITS 4

// stores the reorder buffer may retire per cycle
`define SQ_COMMIT_WIDTH 2

// access size, low two bits of the memory function
`define MEM_BYTE 2'd0
`define MEM_HALF 2'd1
`define MEM_WORD 2'd2

`endif

// File: sq_forward.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module sq_forward
    import sq_pkg::*;
(
    sq_view_if.viewer view,
    input  addr_t      load_addr,
    input  mem_func_t  load_func,
    input  sq_idx_t    load_bound,
    output data_t      fwd_value,
    output byte_mask_t fwd_mask,
    output logic       fwd_valid
);

    // byte lanes touched by an access of this size and offset
    function automatic byte_mask_t lane_mask(mem_func_t func, logic [1:0] offset);
        byte_mask_t mask;
        case (func[1:0])
            `MEM_BYTE: mask = 4'b0001 << offset;
            `MEM_HALF: mask = offset[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

    byte_mask_t need;

    // oldest to youngest, so a younger store overwrites older bytes
    always_comb begin
        sq_idx_t    idx;
        logic       stop;
        byte_mask_t lanes;

        fwd_value = '0;
        fwd_mask  = '0;
        idx       = view.head;
        stop      = 1'b0;
        for (int j = 0; j < `SQ_LEN; j++) begin
            // stores from load_bound on are younger than the load
            if (idx == load_bound) begin
                stop = 1'b1;
            end
            lanes = lane_mask(view.entry_func[idx], view.entry_addr[idx][1:0]);
            if (!stop && view.entry_valid[idx] && view.entry_ready[idx] &&
                view.entry_addr[idx][31:2] == load_addr[31:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (lanes[b]) begin
                        fwd_mask[b]         = 1'b1;
                        fwd_value[8*b +: 8] = view.entry_data[idx][8*b +: 8];
                    end
                end
            end
            idx = (idx == sq_idx_t'(`SQ_SLOTS - 1)) ? '0 : idx + 1'b1;
        end
    end

    // lanes the load itself reads
    assign need = lane_mask(load_func, load_addr[1:0]);

    assign fwd_valid = ((need & ~fwd_mask) == 4'b0000);

endmodule

// File: sq_pkg.sv
`include "sq_consts.svh"

package sq_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic signed [11:0] imm_t;
    typedef logic [`SQ_IDX_BITS-1:0] sq_idx_t;
    typedef logic [1:0] commit_cnt_t;

    // bits 1:0 size, bit 2 unsigned
    typedef logic [2:0] mem_func_t;
    typedef logic [3:0] byte_mask_t;

endpackage

// File: sq_view_if.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

interface sq_view_if
    import sq_pkg::*;
();

    // one element per ring slot
    logic      [`SQ_SLOTS-1:0] entry_valid;
    logic      [`SQ_SLOTS-1:0] entry_ready;
    addr_t     [`SQ_SLOTS-1:0] entry_addr;
    // already in its byte lanes
    data_t     [`SQ_SLOTS-1:0] entry_data;
    mem_func_t [`SQ_SLOTS-1:0] entry_func;
    sq_idx_t                   head;

    modport owner (output entry_valid, entry_ready, entry_addr, entry_data, entry_func, head);
    modport viewer (input entry_valid, entry_ready, entry_addr, entry_data, entry_func, head);

endinterface

// File: store_queue_top.sv
`timescale 1ns/1ps

module store_queue_top
    import sq_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    // dispatch
    input  logic        dispatch_valid,
    input  mem_func_t   dispatch_func,
    output logic        almost_full,
    output sq_idx_t     tail,
    // issue from the reservation station
    input  logic        issue,
    input  addr_t       issue_base,
    input  imm_t        issue_offset,
    input  data_t       issue_data,
    input  sq_idx_t     issue_idx,
    // reorder buffer commit
    input  commit_cnt_t commit_count,
    output commit_cnt_t sent_count,
    // data cache drain
    output logic        dcache_valid,
    output addr_t       dcache_addr,
    output data_t       dcache_data,
    output mem_func_t   dcache_func,
    input  logic        dcache_accept,
    // load lookup
    input  addr_t       load_addr,
    input  mem_func_t   load_func,
    input  sq_idx_t     load_bound,
    output data_t       fwd_value,
    output byte_mask_t  fwd_mask,
    output logic        fwd_valid,
    output sq_idx_t     head,
    output sq_idx_t     tail_ready
);

    logic    ag_valid;
    addr_t   ag_addr;
    data_t   ag_data;
    sq_idx_t ag_idx;

    sq_view_if view_bus ();

    sq_addr_gen u_addr_gen (
        .clock(clock), .reset(reset), .squash(squash),
        .issue(issue), .issue_base(issue_base), .issue_offset(issue_offset),
        .issue_data(issue_data), .issue_idx_in(issue_idx),
        .issue_valid(ag_valid), .issue_addr(ag_addr),
        .issue_store_data(ag_data), .issue_idx(ag_idx)
    );

    sq_buffer u_buffer (
        .clock(clock), .reset(reset), .squash(squash),
        .dispatch_valid(dispatch_valid), .dispatch_func(dispatch_func),
        .issue_valid(ag_valid), .issue_idx(ag_idx), .issue_addr(ag_addr),
        .issue_store_data(ag_data), .commit_count(commit_count),
        .dcache_accept(dcache_accept), .almost_full(almost_full), .tail(tail),
        .sent_count(sent_count), .head(head), .tail_ready(tail_ready),
        .dcache_valid(dcache_valid), .dcache_addr(dcache_addr),
        .dcache_data(dcache_data), .dcache_func(dcache_func), .view(view_bus.owner)
    );

    sq_forward u_forward (
        .view(view_bus.viewer), .load_addr(load_addr), .load_func(load_func),
        .load_bound(load_bound), .fwd_value(fwd_value), .fwd_mask(fwd_mask),
        .fwd_valid(fwd_valid)
    );

endmodule

// File: tb_store_queue.sv
`timescale 1ns/1ps
`include "sq_consts.svh"

module tb_store_queue
    import sq_pkg::*;
();

    logic        clock, reset, squash, dispatch_valid, issue, dcache_accept;
    logic        almost_full, dcache_valid, fwd_valid;
    mem_func_t   dispatch_func, load_func, dcache_func;
    addr_t       issue_base, load_addr, dcache_addr;
    imm_t        issue_offset;
    data_t       issue_data, dcache_data, fwd_value;
    sq_idx_t     issue_idx, load_bound, tail, head, tail_ready;
    commit_cnt_t commit_count, sent_count;
    byte_mask_t  fwd_mask;

    // ring model stepped at every rising edge
    logic      m_valid [`SQ_SLOTS], m_ready [`SQ_SLOTS], m_comm [`SQ_SLOTS];
    addr_t     m_addr [`SQ_SLOTS];
    data_t     m_data [`SQ_SLOTS];
    mem_func_t m_func [`SQ_SLOTS];
    int        m_head, m_tail, m_ctail;
    // store held in the address stage
    logic      pend_valid;
    int        pend_idx;
    addr_t     pend_addr;
    data_t     pend_data;

    logic [15:0] lfsr;
    int          errors, checks, test_start;
    logic        hung;
    string       test_name;

    store_queue_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // taps x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // unused size code 3 folds onto a word
    function automatic mem_func_t legal_func(logic [2:0] f);
        return (f[1:0] == 2'd3) ? {f[2], 2'd2} : f;
    endfunction

    function automatic addr_t align_addr(addr_t a, mem_func_t f);
        return (f[1:0] == 2'd0) ? a : (f[1:0] == 2'd1) ? {a[31:1], 1'b0} : {a[31:2], 2'b00};
    endfunction

    // lanes covered by a size aligned access
    function automatic byte_mask_t lanes_of(mem_func_t f, logic [1:0] off);
        return (f[1:0] == 2'd0) ? 4'b0001 << off : (f[1:0] == 2'd1) ? 4'b0011 << off : 4'b1111;
    endfunction

    function automatic data_t bytes_of(byte_mask_t m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic data_t align_store(data_t d, logic [1:0] off, mem_func_t f);
        data_t keep;
        keep = (f[1:0] == 2'd0) ? 32'h0000_00ff : (f[1:0] == 2'd1) ? 32'h0000_ffff : '1;
        return (d & keep) << (8 * off);
    endfunction

    function automatic int count_valid();
        int n;
        n = 0;
        foreach (m_valid[i]) n += m_valid[i];
        return n;
    endfunction

    // count of ready stores in a row from start up to limit
    function automatic int walk(int start, int limit);
        int n;
        n = 0;
        while (n < limit && m_valid[(start + n) % `SQ_SLOTS] && m_ready[(start + n) % `SQ_SLOTS])
            n++;
        return n;
    endfunction

    function automatic int model_sent();
        int want;
        want = (commit_count < `SQ_COMMIT_WIDTH) ? int'(commit_count) : `SQ_COMMIT_WIDTH;
        return walk(m_ctail, want);
    endfunction

    // merge older stores first so younger bytes win
    task automatic model_forward(output byte_mask_t mask, output data_t value);
        int         idx;
        byte_mask_t ln;
        mask  = '0;
        value = '0;
        idx   = m_head;
        for (int n = 0; n < `SQ_LEN && idx != load_bound; n++) begin
            ln = lanes_of(m_func[idx], m_addr[idx][1:0]);
            if (m_valid[idx] && m_ready[idx] && m_addr[idx][31:2] == load_addr[31:2]) begin
                mask  = mask | ln;
                value = (value & ~bytes_of(ln)) | (m_data[idx] & bytes_of(ln));
            end
            idx = (idx + 1) % `SQ_SLOTS;
        end
    endtask

    task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs();
        byte_mask_t emask;
        data_t      evalue;
        logic       edv;
        model_forward(emask, evalue);
        edv = m_valid[m_head] && m_comm[m_head];
        check_val("tail", m_tail, tail);
        check_val("head", m_head, head);
        check_val("almost_full", count_valid() == `SQ_LEN, almost_full);
        check_val("tail_ready", (m_head + walk(m_head, `SQ_LEN)) % `SQ_SLOTS, tail_ready);
        check_val("sent_count", model_sent(), sent_count);
        check_val("dcache_valid", edv, dcache_valid);
        if (edv) begin
            check_val("dcache_addr", m_addr[m_head], dcache_addr);
            check_val("dcache_data", m_data[m_head], dcache_data);
            check_val("dcache_func", m_func[m_head], dcache_func);
        end
        check_val("fwd_mask", emask, fwd_mask);
        check_val("fwd_value", evalue & bytes_of(emask), fwd_value & bytes_of(emask));
        check_val("fwd_valid", (lanes_of(load_func, load_addr[1:0]) & ~emask) == 0, fwd_valid);
    endtask

    // apply the inputs sampled at this edge to the state before it
    task automatic model_step();
        int   sent;
        logic full, drain;
        sent  = model_sent();
        full  = count_valid() == `SQ_LEN;
        drain = m_valid[m_head] && m_comm[m_head] && dcache_accept;
        if (pend_valid && m_valid[pend_idx]) begin
            m_ready[pend_idx] = 1'b1;
            m_addr[pend_idx]  = pend_addr;
            m_data[pend_idx]  = align_store(pend_data, pend_addr[1:0], m_func[pend_idx]);
        end
        repeat (sent) begin
            m_comm[m_ctail] = 1'b1;
            m_ctail         = (m_ctail + 1) % `SQ_SLOTS;
        end
        if (drain) begin
            {m_valid[m_head], m_ready[m_head], m_comm[m_head]} = 3'b000;
            m_head = (m_head + 1) % `SQ_SLOTS;
        end
        if (dispatch_valid && !full) begin
            {m_valid[m_tail], m_ready[m_tail], m_comm[m_tail]} = 3'b100;
            m_func[m_tail] = dispatch_func;
            m_tail         = (m_tail + 1) % `SQ_SLOTS;
        end
        if (squash) begin
            foreach (m_valid[i]) begin
                m_valid[i] = m_valid[i] & m_comm[i];
                m_ready[i] = m_ready[i] & m_comm[i];
            end
            m_tail = m_ctail;
        end
        pend_valid = issue && !squash;
        pend_idx   = issue_idx;
        pend_addr  = issue_base + 32'($signed(issue_offset));
        pend_data  = issue_data;
        if (reset) begin
            foreach (m_valid[i]) {m_valid[i], m_ready[i], m_comm[i]} = 3'b000;
            {m_head, m_tail, m_ctail, pend_valid} = '0;
        end
    endtask

    // check in mid cycle then step the model on the edge and drive 5 ns later
    task automatic cycle();
        #40;
        if (!reset) check_outputs();
        @(posedge clock);
        model_step();
        #5;
    endtask

    // probabilities are in eighths
    task automatic drive_random(int p_disp, int p_issue, int p_commit, int p_accept, int p_squash);
        int idx;
        dispatch_valid = rand_bits(3) < p_disp;
        dispatch_func  = legal_func(3'(rand_bits(3)));
        // pick a dispatched store that has no address yet
        idx   = rand_bits(4) % `SQ_SLOTS;
        issue = 1'b0;
        if (rand_bits(3) < p_issue) begin
            for (int n = 0; n < `SQ_SLOTS && !issue; n++) begin
                if (m_valid[idx] && !m_ready[idx]) issue = 1'b1;
                else idx = (idx + 1) % `SQ_SLOTS;
            end
        end
        issue_idx     = sq_idx_t'(idx);
        issue_offset  = imm_t'(rand_bits(12));
        issue_base    = align_addr(32'h100 | rand_bits(4), m_func[idx]) -
                        32'($signed(issue_offset));
        issue_data    = rand_bits(32);
        commit_count  = (rand_bits(3) < p_commit) ? commit_cnt_t'(1 + rand_bits(1)) : 2'd0;
        dcache_accept = rand_bits(3) < p_accept;
        squash        = rand_bits(3) < p_squash;
        load_func     = legal_func(3'(rand_bits(3)));
        load_addr     = align_addr(32'h100 | rand_bits(4), load_func);
        load_bound    = sq_idx_t'(rand_bits(4) % `SQ_SLOTS);
    endtask

    task automatic run_test(string name, int cycles, int p_disp, int p_issue, int p_commit,
                            int p_accept, int p_squash, bit drain);
        int waited;
        if (hung) return;
        test_name  = name;
        test_start = errors;
        repeat (cycles) begin
            drive_random(p_disp, p_issue, p_commit, p_accept, p_squash);
            cycle();
        end
        // empty the queue while stores keep issuing and committing
        waited = 0;
        while (drain && count_valid() != 0 && waited < 400) begin
            drive_random(0, 6, 6, 5, 0);
            cycle();
            waited++;
        end
        if (drain && count_valid() != 0) begin
            $display("%s: queue did not drain within 400 cycles", name);
            hung = 1'b1;
        end else begin
            $display("%s: %0d errors", name, errors - test_start);
        end
    endtask

    initial begin
        lfsr      = 16'd39294;
        errors    = 0;
        checks    = 0;
        hung      = 1'b0;
        test_name = "reset";
        reset     = 1'b1;
        {squash, dispatch_valid, issue, dcache_accept, commit_count, load_bound} = '0;
        {dispatch_func, issue_base, issue_offset, issue_data, issue_idx, load_addr} = '0;
        load_func = 3'b010;
        repeat (8) cycle();
        reset = 1'b0;
        run_test("allocation", 10, 8, 0, 0, 0, 0, 1'b0);
        run_test("issue", 24, 0, 6, 0, 0, 0, 1'b0);
        run_test("commit_drain", 80, 4, 5, 5, 4, 0, 1'b1);
        run_test("forwarding", 60, 5, 6, 1, 2, 0, 1'b1);
        run_test("squash", 80, 4, 5, 3, 4, 1, 1'b1);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !hung) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
